// File: design/lookup_pkg.sv
`default_nettype none

package lookup_pkg;

    localparam int PORT_NUM   = 4;
    localparam int HASH_WIDTH = 12;
    localparam int CTX_DEPTH  = 8;   // max lookups in flight

    localparam logic [47:0] LOCAL_MAC = 48'h000000000001;

    // destination classification
    localparam int MAC_SLICE_W = 16;
    localparam int MAC_SLICES  = 48 / MAC_SLICE_W;
    localparam int MCAST_BIT   = 40;   // group bit of the first octet

    // queue pointer and occupancy widths
    localparam int CTX_PTR_W = $clog2(CTX_DEPTH);
    localparam int CTX_CNT_W = $clog2(CTX_DEPTH + 1);

    typedef logic [47:0]           mac_t;
    typedef logic [11:0]           vlan_t;
    typedef logic [HASH_WIDTH-1:0] hash_t;
    typedef logic [PORT_NUM-1:0]   port_mask_t;
    typedef logic [PORT_NUM:0]     tx_port_t;   // msb alone = frame for this switch

    localparam tx_port_t SELF_PORT = {1'b1, {PORT_NUM{1'b0}}};

    typedef enum logic [1:0] {
        CAST_UNICAST   = 2'b00,
        CAST_MULTICAST = 2'b01,
        CAST_BROADCAST = 2'b10,
        CAST_FLOOD     = 2'b11
    } cast_t;

    // one queue entry per frame awaiting its table answer
    typedef struct packed {
        port_mask_t flood_mask;
        logic       is_self;
        logic       is_bcast;
        logic       is_mcast;
    } lookup_ctx_t;

endpackage

`default_nettype wire

// File: design/mac_key_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mac_key_stage
    import lookup_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,

    input  wire logic        i_key_vld,
    input  wire mac_t        i_dmac,
    input  wire mac_t        i_smac,
    input  wire hash_t       i_dmac_hash,
    input  wire hash_t       i_smac_hash,
    input  wire vlan_t       i_vlan_id,
    input  wire port_mask_t  i_rx_port,

    output logic             o_req_vld,
    output hash_t            o_req_addr,
    output mac_t             o_req_dmac,
    output vlan_t            o_req_vlan_id,

    output logic             o_learn_vld,
    output hash_t            o_learn_addr,
    output mac_t             o_learn_smac,
    output port_mask_t       o_learn_port,

    output logic             o_ctx_push,
    output lookup_ctx_t      o_ctx
);

    logic       key_vld_q;   // one-cycle request strobe
    mac_t       dmac_q;
    mac_t       smac_q;
    hash_t      dmac_hash_q;
    hash_t      smac_hash_q;
    vlan_t      vlan_q;
    port_mask_t rx_port_q;

    logic [MAC_SLICES-1:0] self_slice;    // per-slice match against local mac
    logic [MAC_SLICES-1:0] bcast_slice;   // per-slice all-ones

    // key register, data held until the next key
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            key_vld_q   <= 1'b0;
            dmac_q      <= '0;
            smac_q      <= '0;
            dmac_hash_q <= '0;
            smac_hash_q <= '0;
            vlan_q      <= '0;
            rx_port_q   <= '0;
        end else begin
            key_vld_q <= i_key_vld;
            if (i_key_vld) begin
                dmac_q      <= i_dmac;
                smac_q      <= i_smac;
                dmac_hash_q <= i_dmac_hash;
                smac_hash_q <= i_smac_hash;
                vlan_q      <= i_vlan_id;
                rx_port_q   <= i_rx_port;
            end
        end
    end

    // 16-bit slice compares keep the equality trees shallow
    always_comb begin
        for (int i = 0; i < MAC_SLICES; i++) begin
            self_slice[i]  = (dmac_q[i*MAC_SLICE_W +: MAC_SLICE_W]
                              == LOCAL_MAC[i*MAC_SLICE_W +: MAC_SLICE_W]);
            bcast_slice[i] = (dmac_q[i*MAC_SLICE_W +: MAC_SLICE_W]
                              == {MAC_SLICE_W{1'b1}});
        end
    end

    always_comb begin
        o_ctx.flood_mask = ~rx_port_q;        // every port but the one it came in on
        o_ctx.is_self    = &self_slice;
        o_ctx.is_bcast   = &bcast_slice;
        o_ctx.is_mcast   = dmac_q[MCAST_BIT];
    end

    // destination table request
    assign o_req_vld     = key_vld_q;
    assign o_req_addr    = dmac_hash_q;
    assign o_req_dmac    = dmac_q;
    assign o_req_vlan_id = vlan_q;

    // source learning request
    assign o_learn_vld  = key_vld_q;
    assign o_learn_addr = smac_hash_q;
    assign o_learn_smac = smac_q;
    assign o_learn_port = rx_port_q;

    assign o_ctx_push = key_vld_q;   // context queued with its request

    // a frame enters on exactly one port
    rx_port_onehot: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_key_vld |-> $onehot(i_rx_port))
        else $error("receive port mask is not one-hot");

endmodule

`default_nettype wire

// File: design/lookup_ctx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_ctx_fifo
    import lookup_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,

    input  wire logic        i_push,
    input  wire lookup_ctx_t i_push_ctx,
    input  wire logic        i_pop,

    output lookup_ctx_t      o_head_ctx,
    output logic             o_empty,
    output logic             o_full
);

    lookup_ctx_t          mem [CTX_DEPTH];
    logic [CTX_PTR_W-1:0] wr_ptr;
    logic [CTX_PTR_W-1:0] rd_ptr;
    logic [CTX_CNT_W-1:0] count;   // entries held
    logic                 do_push;
    logic                 do_pop;

    function automatic logic [CTX_PTR_W-1:0] next_ptr(input logic [CTX_PTR_W-1:0] ptr);
        if (ptr == CTX_PTR_W'(CTX_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign o_empty = (count == '0);
    assign o_full  = (count == CTX_CNT_W'(CTX_DEPTH));

    // a full queue still takes a push when the head leaves the same cycle
    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push)
            mem[wr_ptr] <= i_push_ctx;
    end

    assign o_head_ctx = mem[rd_ptr];   // fall-through head

    // more requests in flight than the queue can track
    no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_push && o_full |-> i_pop)
        else $error("context queue overflow");

    no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_pop |-> !o_empty)
        else $error("context queue underflow");

endmodule

`default_nettype wire

// File: design/port_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module port_resolve
    import lookup_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,

    input  wire logic        i_lookup_vld,
    input  wire port_mask_t  i_lookup_port,
    input  wire logic        i_lookup_miss,

    input  wire lookup_ctx_t i_head_ctx,
    input  wire logic        i_ctx_empty,
    output logic             o_pop,

    output tx_port_t         o_tx_port,
    output logic             o_tx_port_vld,
    output cast_t            o_cast
);

    logic       use_answer;    // table gave a usable port
    port_mask_t answer_port;   // answer or flood mask
    tx_port_t   next_port;
    cast_t      next_cast;

    // answers come back in request order, so the head is this answer's frame
    assign o_pop = i_lookup_vld;

    assign use_answer  = !i_lookup_miss && (i_lookup_port != '0);
    assign answer_port = use_answer ? i_lookup_port : i_head_ctx.flood_mask;

    always_comb begin
        if (i_head_ctx.is_self) begin
            next_port = SELF_PORT;   // ours, table answer ignored
            next_cast = CAST_UNICAST;
        end else begin
            next_port = {1'b0, answer_port};
            if (i_head_ctx.is_bcast)
                next_cast = CAST_BROADCAST;
            else if (i_head_ctx.is_mcast)
                next_cast = CAST_MULTICAST;
            else if (answer_port == i_head_ctx.flood_mask && answer_port != '0)
                next_cast = CAST_FLOOD;
            else
                next_cast = CAST_UNICAST;
        end
    end

    // result held until the next answer
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            o_tx_port_vld <= 1'b0;
            o_tx_port     <= '0;
            o_cast        <= CAST_UNICAST;
        end else begin
            o_tx_port_vld <= o_pop;
            if (o_pop) begin
                o_tx_port <= next_port;
                o_cast    <= next_cast;
            end
        end
    end

    // every answer must match a request still in the queue
    answer_has_ctx: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_lookup_vld |-> !i_ctx_empty)
        else $error("table answer with no pending lookup");

endmodule

`default_nettype wire

// File: design/lookup_mng.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_mng
    import lookup_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,

    // frame key
    input  wire logic        i_key_vld,
    input  wire mac_t        i_dmac,
    input  wire mac_t        i_smac,
    input  wire hash_t       i_dmac_hash,
    input  wire hash_t       i_smac_hash,
    input  wire vlan_t       i_vlan_id,
    input  wire port_mask_t  i_rx_port,

    // destination table request
    output logic             o_req_vld,
    output hash_t            o_req_addr,
    output mac_t             o_req_dmac,
    output vlan_t            o_req_vlan_id,

    // source learning request
    output logic             o_learn_vld,
    output hash_t            o_learn_addr,
    output mac_t             o_learn_smac,
    output port_mask_t       o_learn_port,

    // destination table answer
    input  wire logic        i_lookup_vld,
    input  wire port_mask_t  i_lookup_port,
    input  wire logic        i_lookup_miss,

    // forwarding result
    output tx_port_t         o_tx_port,
    output logic             o_tx_port_vld,
    output cast_t            o_cast
);

    logic        ctx_push;
    lookup_ctx_t ctx;
    lookup_ctx_t head_ctx;
    logic        ctx_empty;
    logic        ctx_pop;

    mac_key_stage u_key_stage (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_key_vld     (i_key_vld),
        .i_dmac        (i_dmac),
        .i_smac        (i_smac),
        .i_dmac_hash   (i_dmac_hash),
        .i_smac_hash   (i_smac_hash),
        .i_vlan_id     (i_vlan_id),
        .i_rx_port     (i_rx_port),
        .o_req_vld     (o_req_vld),
        .o_req_addr    (o_req_addr),
        .o_req_dmac    (o_req_dmac),
        .o_req_vlan_id (o_req_vlan_id),
        .o_learn_vld   (o_learn_vld),
        .o_learn_addr  (o_learn_addr),
        .o_learn_smac  (o_learn_smac),
        .o_learn_port  (o_learn_port),
        .o_ctx_push    (ctx_push),
        .o_ctx         (ctx)
    );

    lookup_ctx_fifo u_ctx_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_push     (ctx_push),
        .i_push_ctx (ctx),
        .i_pop      (ctx_pop),
        .o_head_ctx (head_ctx),
        .o_empty    (ctx_empty),
        .o_full     ()   // overflow is caught inside the queue
    );

    port_resolve u_resolve (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_lookup_vld  (i_lookup_vld),
        .i_lookup_port (i_lookup_port),
        .i_lookup_miss (i_lookup_miss),
        .i_head_ctx    (head_ctx),
        .i_ctx_empty   (ctx_empty),
        .o_pop         (ctx_pop),
        .o_tx_port     (o_tx_port),
        .o_tx_port_vld (o_tx_port_vld),
        .o_cast        (o_cast)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD = 20;   // 40 ns clock
    localparam int RST_CYCLES  = 16;
    localparam int RELEASE_DLY = 2;    // release clear of the edge

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b0;   // active low
        repeat (RST_CYCLES) @(posedge o_clk);
        #RELEASE_DLY;
        o_rst = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/lookup_mng_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_mng_tb
    import lookup_pkg::*;
();

    localparam int NUM_ROWS     = 14;
    localparam int DRIVE_DLY    = 2;
    localparam int DRAIN_CYCLES = 8;   // room for a stray extra result

    typedef struct packed {
        mac_t       dmac;
        mac_t       smac;
        hash_t      dhash;
        hash_t      shash;
        vlan_t      vlan;
        port_mask_t rx;
        port_mask_t ans;    // table answer
        logic       miss;
        logic [3:0] gap;    // idle cycles after the key
    } stim_row_t;

    localparam stim_row_t STIM [NUM_ROWS] = '{
        // dmac             smac              dhash    shash    vlan     rx    ans   miss  gap
        '{48'h0a1b2c3d4e5f, 48'h02000000a000, 12'h0a1, 12'h5a0, 12'h001, 4'h1, 4'h4, 1'b0, 4'd3},
        '{48'h020000001234, 48'h02000000a001, 12'h234, 12'h5a1, 12'h001, 4'h2, 4'hd, 1'b0, 4'd3},
        '{48'h0a0000000002, 48'h02000000a002, 12'h002, 12'h5a2, 12'h002, 4'h4, 4'h2, 1'b1, 4'd2},
        '{48'h0c0000000003, 48'h02000000a003, 12'h003, 12'h5a3, 12'h002, 4'h8, 4'h0, 1'b0, 4'd2},
        '{48'hffffffffffff, 48'h02000000a004, 12'hfff, 12'h5a4, 12'h003, 4'h1, 4'h0, 1'b1, 4'd2},
        '{48'hffffffffffff, 48'h02000000a005, 12'hffe, 12'h5a5, 12'h003, 4'h4, 4'h2, 1'b0, 4'd2},
        '{48'h01005e000001, 48'h02000000a006, 12'h501, 12'h5a6, 12'h064, 4'h2, 4'h9, 1'b0, 4'd2},
        '{48'h333300000001, 48'h02000000a007, 12'h331, 12'h5a7, 12'h064, 4'h8, 4'h0, 1'b1, 4'd2},
        '{48'h000000000001, 48'h02000000a008, 12'h001, 12'h5a8, 12'h00a, 4'h1, 4'h2, 1'b0, 4'd2},
        '{48'h000000000001, 48'h02000000a009, 12'h001, 12'h5a9, 12'h00a, 4'h4, 4'h0, 1'b1, 4'd0},
        '{48'h000000010001, 48'h02000000a00a, 12'h011, 12'h5aa, 12'h7ff, 4'h1, 4'h8, 1'b0, 4'd0},
        '{48'h00aabbcc0011, 48'h02000000a00b, 12'hc11, 12'h5ab, 12'h7ff, 4'h2, 4'h4, 1'b1, 4'd0},
        '{48'h01005e7f0012, 48'h02000000a00c, 12'he12, 12'h5ac, 12'h7ff, 4'h4, 4'h1, 1'b0, 4'd0},
        '{48'h000000000001, 48'h02000000a00d, 12'h001, 12'h5ad, 12'h7ff, 4'h8, 4'h7, 1'b0, 4'd4}
    };

    logic clk;
    logic rst;
    logic i_key_vld;
    mac_t i_dmac;
    mac_t i_smac;
    hash_t i_dmac_hash;
    hash_t i_smac_hash;
    vlan_t i_vlan_id;
    port_mask_t i_rx_port;
    logic i_lookup_vld;
    port_mask_t i_lookup_port;
    logic i_lookup_miss;
    logic o_req_vld;
    hash_t o_req_addr;
    mac_t o_req_dmac;
    vlan_t o_req_vlan_id;
    logic o_learn_vld;
    hash_t o_learn_addr;
    mac_t o_learn_smac;
    port_mask_t o_learn_port;
    tx_port_t o_tx_port;
    logic o_tx_port_vld;
    cast_t o_cast;

    int cycle_cnt = 0;
    int cycle_limit = 0;
    int value_errors = 0;
    int flow_errors = 0;
    int req_idx = 0;          // next row whose request is due
    int key_cycle [NUM_ROWS];
    int exp_rows [$];         // rows still waiting for a result
    int pend_rows [$];        // requests not yet answered
    int pend_due [$];
    logic [31:0] lfsr_state = 32'h086f_734e;

    tb_clock_gen u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    lookup_mng u_lookup_mng (
        .i_clk(clk), .i_rst(rst),
        .i_key_vld(i_key_vld), .i_dmac(i_dmac), .i_smac(i_smac),
        .i_dmac_hash(i_dmac_hash), .i_smac_hash(i_smac_hash),
        .i_vlan_id(i_vlan_id), .i_rx_port(i_rx_port),
        .o_req_vld(o_req_vld), .o_req_addr(o_req_addr),
        .o_req_dmac(o_req_dmac), .o_req_vlan_id(o_req_vlan_id),
        .o_learn_vld(o_learn_vld), .o_learn_addr(o_learn_addr),
        .o_learn_smac(o_learn_smac), .o_learn_port(o_learn_port),
        .i_lookup_vld(i_lookup_vld), .i_lookup_port(i_lookup_port),
        .i_lookup_miss(i_lookup_miss),
        .o_tx_port(o_tx_port), .o_tx_port_vld(o_tx_port_vld), .o_cast(o_cast)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // answer delay of 1 to 4 cycles, two lfsr bits
    task automatic random_delay(output int cycles);
        logic [1:0] bits;
        bits = 2'b00;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[0], lfsr_state[0]};
        end
        cycles = 1 + int'(bits);
    endtask

    // forwarding rules, worked out per row
    function automatic tx_port_t expected_port(input stim_row_t r);
        if (r.dmac == LOCAL_MAC)
            return tx_port_t'(1) << PORT_NUM;   // self code
        if (!r.miss && r.ans != 4'b0000)
            return {1'b0, r.ans};
        return {1'b0, ~r.rx};
    endfunction

    function automatic cast_t expected_cast(input stim_row_t r);
        tx_port_t port;
        port = expected_port(r);
        if (r.dmac == LOCAL_MAC)
            return CAST_UNICAST;
        if (r.dmac == {48{1'b1}})
            return CAST_BROADCAST;
        if (r.dmac[40])
            return CAST_MULTICAST;
        if (port == {1'b0, ~r.rx} && port != '0)
            return CAST_FLOOD;
        return CAST_UNICAST;
    endfunction

    task automatic check_tx_port(input tx_port_t exp_port, input tx_port_t act_port);
        if (act_port !== exp_port) begin
            $display("error at %0t ns: o_tx_port expected %b, got %b", $time, exp_port, act_port);
            value_errors++;
        end
    endtask

    task automatic check_cast(input cast_t exp_cast, input cast_t act_cast);
        if (act_cast !== exp_cast) begin
            $display("error at %0t ns: o_cast expected %s, got %s",
                     $time, exp_cast.name(), act_cast.name());
            value_errors++;
        end
    endtask

    task automatic check_req(input string addr_name, input string mac_name,
                             input hash_t exp_addr, input mac_t exp_mac,
                             input hash_t act_addr, input mac_t act_mac);
        if (act_addr !== exp_addr) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, addr_name, exp_addr, act_addr);
            value_errors++;
        end
        if (act_mac !== exp_mac) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, mac_name, exp_mac, act_mac);
            value_errors++;
        end
    endtask

    task automatic check_vlan(input vlan_t exp_vlan, input vlan_t act_vlan);
        if (act_vlan !== exp_vlan) begin
            $display("error at %0t ns: o_req_vlan_id expected %h, got %h",
                     $time, exp_vlan, act_vlan);
            value_errors++;
        end
    endtask

    task automatic check_mask(input port_mask_t exp_mask, input port_mask_t act_mask);
        if (act_mask !== exp_mask) begin
            $display("error at %0t ns: o_learn_port expected %b, got %b",
                     $time, exp_mask, act_mask);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("run stopped at cycle %0d with %0d results still missing",
                     cycle_cnt, exp_rows.size());
            $display("Verification failed");
            $finish;
        end
    end

    // table model and result monitor
    initial begin
        stim_row_t row;
        int        delay;
        int        idx;
        i_lookup_vld  = 1'b0;
        i_lookup_port = '0;
        i_lookup_miss = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            i_lookup_vld = 1'b0;
            if (o_req_vld || o_learn_vld) begin
                if (req_idx >= NUM_ROWS) begin
                    $display("request at %0t ns with no key behind it", $time);
                    flow_errors++;
                end else begin
                    row = STIM[req_idx];
                    if (!(o_req_vld && o_learn_vld)) begin
                        $display("row %0d did not get both request pulses together", req_idx);
                        flow_errors++;
                    end
                    if (cycle_cnt != key_cycle[req_idx] + 1) begin
                        $display("request for row %0d came at cycle %0d instead of %0d",
                                 req_idx, cycle_cnt, key_cycle[req_idx] + 1);
                        flow_errors++;
                    end
                    check_req("o_req_addr", "o_req_dmac", row.dhash, row.dmac,
                              o_req_addr, o_req_dmac);
                    check_vlan(row.vlan, o_req_vlan_id);
                    check_req("o_learn_addr", "o_learn_smac", row.shash, row.smac,
                              o_learn_addr, o_learn_smac);
                    check_mask(row.rx, o_learn_port);
                    random_delay(delay);
                    pend_rows.push_back(req_idx);
                    pend_due.push_back(cycle_cnt + delay);
                    req_idx++;
                end
            end
            // answers strictly in request order
            if (pend_rows.size() > 0 && cycle_cnt >= pend_due[0]) begin
                row = STIM[pend_rows.pop_front()];
                void'(pend_due.pop_front());
                i_lookup_vld  = 1'b1;
                i_lookup_port = row.ans;
                i_lookup_miss = row.miss;
            end
            if (o_tx_port_vld) begin
                if (exp_rows.size() == 0) begin
                    $display("result at %0t ns while no frame was waiting for one", $time);
                    flow_errors++;
                end else begin
                    idx = exp_rows.pop_front();
                    check_tx_port(expected_port(STIM[idx]), o_tx_port);
                    check_cast(expected_cast(STIM[idx]), o_cast);
                end
            end
        end
    end

    initial begin
        i_key_vld   = 1'b0;
        i_dmac      = '0;
        i_smac      = '0;
        i_dmac_hash = '0;
        i_smac_hash = '0;
        i_vlan_id   = '0;
        i_rx_port   = '0;
        cycle_limit = NUM_ROWS * 6 + 100;
        for (int i = 0; i < NUM_ROWS; i++)
            cycle_limit += int'(STIM[i].gap);
        @(posedge rst);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            i_key_vld   = 1'b1;
            i_dmac      = STIM[i].dmac;
            i_smac      = STIM[i].smac;
            i_dmac_hash = STIM[i].dhash;
            i_smac_hash = STIM[i].shash;
            i_vlan_id   = STIM[i].vlan;
            i_rx_port   = STIM[i].rx;
            key_cycle[i] = cycle_cnt;
            exp_rows.push_back(i);
            repeat (STIM[i].gap) begin
                @(posedge clk);
                #DRIVE_DLY;
                i_key_vld = 1'b0;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        i_key_vld = 1'b0;
        while (req_idx < NUM_ROWS || exp_rows.size() > 0)
            @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("checks done with %0d value errors and %0d other errors",
                 value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
design/lookup_pkg.sv
design/mac_key_stage.sv
design/lookup_ctx_fifo.sv
design/port_resolve.sv
design/lookup_mng.sv
verification/tb_clock_gen.sv
verification/lookup_mng_tb.sv

// File: Makefile
TOP       ?= lookup_mng_tb
FILELIST  ?= list.f
LOG       ?= sim.log
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: TOP FILELIST LOG BUILD VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "test target: pass"; \
	else \
		echo "test target: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
